// File: logic/fetch_align_pkg.sv
package fetch_align_pkg;

    // Base opcodes used by the expander and the predecoder.
    localparam logic [6:0] opc_load     = 7'b0000011;
    localparam logic [6:0] opc_misc_mem = 7'b0001111;
    localparam logic [6:0] opc_op_imm   = 7'b0010011;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_store    = 7'b0100011;
    localparam logic [6:0] opc_op       = 7'b0110011;
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_system   = 7'b1110011;

    // Compressed halfword, one view per encoding format.
    typedef union packed {
        struct packed {
            logic [3:0] funct4;
            logic [4:0] rd_rs1;
            logic [4:0] rs2;
            logic [1:0] op;
        } cr;
        struct packed {
            logic [2:0] funct3;
            logic       imm_hi;
            logic [4:0] rd;
            logic [4:0] imm_lo;
            logic [1:0] op;
        } ci;
        struct packed {
            logic [2:0] funct3;
            logic [7:0] imm;
            logic [2:0] rd_p;
            logic [1:0] op;
        } ciw;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1_p;
            logic [1:0] imm_lo;
            logic [2:0] rd_rs2_p;
            logic [1:0] op;
        } cls;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] off_hi;
            logic [2:0] rs1_p;
            logic [4:0] off_lo;
            logic [1:0] op;
        } cb;
        struct packed {
            logic [2:0]  funct3;
            logic [10:0] target;
            logic [1:0]  op;
        } cj;
    } rvc_u;

    typedef enum logic [2:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_jump,
        cls_lui_auipc,
        cls_system,
        cls_illegal
    } inst_class_e;

    // Halfwords are zero-extended in raw.
    typedef struct packed {
        logic        valid;
        logic        compressed;
        logic [31:0] raw;
    } aligned_t;

    typedef struct packed {
        logic        valid;
        logic        compressed;
        logic [31:0] inst;
        inst_class_e cls;
    } issue_t;

endpackage

// File: logic/inst_aligner.sv
`timescale 1ns/1ps

module inst_aligner (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic [31:0]               fetch_word,
    input  logic                      fetch_valid,
    output logic                      stall,
    output fetch_align_pkg::aligned_t aligned
);

    logic [15:0] residue;
    logic        full;
    logic        full_next;
    logic        residue_load;
    logic        residue_rvc;
    logic        low_rvc;

    // Low two bits of 11 mark the first half of a 32-bit instruction.
    assign residue_rvc = residue[1:0] != 2'b11;
    assign low_rvc     = fetch_word[1:0] != 2'b11;

    // Hold fetch while a buffered compressed halfword drains.
    assign stall = full && residue_rvc;

    always_comb begin
        aligned      = '0;
        full_next    = full;
        residue_load = 1'b0;
        if (full && residue_rvc) begin
            // Drain the buffered halfword, no fetch word needed.
            aligned.valid      = 1'b1;
            aligned.compressed = 1'b1;
            aligned.raw        = {16'h0000, residue};
            full_next          = 1'b0;
        end else if (full) begin
            // Upper part of a straddling instruction arrives.
            if (fetch_valid) begin
                aligned.valid = 1'b1;
                aligned.raw   = {fetch_word[15:0], residue};
                residue_load  = 1'b1;
            end
        end else if (fetch_valid) begin
            if (low_rvc) begin
                aligned.valid      = 1'b1;
                aligned.compressed = 1'b1;
                aligned.raw        = {16'h0000, fetch_word[15:0]};
                full_next          = 1'b1;
                residue_load       = 1'b1;
            end else begin
                aligned.valid = 1'b1;
                aligned.raw   = fetch_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            full <= 1'b0;
        end else begin
            full <= full_next;
        end
    end

    // The high half always becomes the residue.
    always_ff @(posedge clk) begin
        if (residue_load) begin
            residue <= fetch_word[31:16];
        end
    end

endmodule

// File: logic/rvc_expand.sv
`timescale 1ns/1ps

module rvc_expand (
    input  fetch_align_pkg::aligned_t    aligned,
    output logic [31:0]                  expanded,
    output fetch_align_pkg::inst_class_e cls
);

    fetch_align_pkg::rvc_u h;

    logic [9:0]  addi4spn_imm;
    logic [6:0]  lsw_imm;
    logic [11:0] ls_imm12;
    logic [5:0]  ci_imm;
    logic [11:0] j_off;
    logic [8:0]  b_off;
    logic [12:0] b_imm;
    logic [4:0]  rs1_p;
    logic [4:0]  rd_rs2_p;

    assign h = aligned.raw[15:0];

    // Scrambled immediates, rebuilt into plain order.
    assign addi4spn_imm = {h.ciw.imm[5:2], h.ciw.imm[7:6], h.ciw.imm[0], h.ciw.imm[1], 2'b00};
    assign lsw_imm      = {h.cls.imm_lo[0], h.cls.imm_hi, h.cls.imm_lo[1], 2'b00};
    assign ls_imm12     = {5'b00000, lsw_imm};
    assign ci_imm       = {h.ci.imm_hi, h.ci.imm_lo};
    assign j_off        = {h.cj.target[10], h.cj.target[6], h.cj.target[8:7], h.cj.target[4],
                           h.cj.target[5], h.cj.target[0], h.cj.target[9], h.cj.target[3:1],
                           1'b0};
    assign b_off        = {h.cb.off_hi[2], h.cb.off_lo[4:3], h.cb.off_lo[0], h.cb.off_hi[1:0],
                           h.cb.off_lo[2:1], 1'b0};
    assign b_imm        = {{4{b_off[8]}}, b_off};

    // Three-bit fields address x8 to x15.
    assign rs1_p    = {2'b01, h.cls.rs1_p};
    assign rd_rs2_p = {2'b01, h.cls.rd_rs2_p};

    always_comb begin
        expanded = 32'h0000_0000;
        cls      = fetch_align_pkg::cls_illegal;
        case (h.cr.op)
            2'b00: begin
                case (h.ciw.funct3)
                    3'b000: begin
                        // C.ADDI4SPN, zero immediate is reserved.
                        if (addi4spn_imm != 10'd0) begin
                            expanded = {2'b00, addi4spn_imm, 5'd2, 3'b000, 2'b01, h.ciw.rd_p,
                                        fetch_align_pkg::opc_op_imm};
                            cls      = fetch_align_pkg::cls_alu;
                        end
                    end
                    3'b010: begin
                        expanded = {ls_imm12, rs1_p, 3'b010, rd_rs2_p,
                                    fetch_align_pkg::opc_load};
                        cls      = fetch_align_pkg::cls_load;
                    end
                    3'b110: begin
                        expanded = {ls_imm12[11:5], rd_rs2_p, rs1_p, 3'b010, ls_imm12[4:0],
                                    fetch_align_pkg::opc_store};
                        cls      = fetch_align_pkg::cls_store;
                    end
                    default: ;
                endcase
            end
            2'b01: begin
                case (h.ci.funct3)
                    3'b000: begin
                        // C.ADDI, also C.NOP when rd is zero.
                        expanded = {{6{ci_imm[5]}}, ci_imm, h.ci.rd, 3'b000, h.ci.rd,
                                    fetch_align_pkg::opc_op_imm};
                        cls      = fetch_align_pkg::cls_alu;
                    end
                    3'b010: begin
                        expanded = {{6{ci_imm[5]}}, ci_imm, 5'd0, 3'b000, h.ci.rd,
                                    fetch_align_pkg::opc_op_imm};
                        cls      = fetch_align_pkg::cls_alu;
                    end
                    3'b011: begin
                        // rd of x2 is C.ADDI16SP, not supported here.
                        if (h.ci.rd != 5'd2 && ci_imm != 6'd0) begin
                            expanded = {{14{ci_imm[5]}}, ci_imm, h.ci.rd,
                                        fetch_align_pkg::opc_lui};
                            cls      = fetch_align_pkg::cls_lui_auipc;
                        end
                    end
                    3'b101: begin
                        expanded = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}}, 5'd0,
                                    fetch_align_pkg::opc_jal};
                        cls      = fetch_align_pkg::cls_jump;
                    end
                    3'b110, 3'b111: begin
                        // BEQZ and BNEZ differ only in funct3 bit 0.
                        expanded = {b_imm[12], b_imm[10:5], 5'd0, {2'b01, h.cb.rs1_p},
                                    2'b00, h.cb.funct3[0], b_imm[4:1], b_imm[11],
                                    fetch_align_pkg::opc_branch};
                        cls      = fetch_align_pkg::cls_branch;
                    end
                    default: ;
                endcase
            end
            2'b10: begin
                // C.JR, C.JALR and C.EBREAK have rs2 of zero.
                if (h.cr.rs2 != 5'd0) begin
                    if (h.cr.funct4 == 4'b1000) begin
                        expanded = {7'b0000000, h.cr.rs2, 5'd0, 3'b000, h.cr.rd_rs1,
                                    fetch_align_pkg::opc_op};
                        cls      = fetch_align_pkg::cls_alu;
                    end else if (h.cr.funct4 == 4'b1001) begin
                        expanded = {7'b0000000, h.cr.rs2, h.cr.rd_rs1, 3'b000, h.cr.rd_rs1,
                                    fetch_align_pkg::opc_op};
                        cls      = fetch_align_pkg::cls_alu;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

// File: logic/inst_predecode.sv
`timescale 1ns/1ps

module inst_predecode (
    input  fetch_align_pkg::aligned_t    aligned,
    output fetch_align_pkg::inst_class_e cls
);

    logic [6:0] opcode;

    assign opcode = aligned.raw[6:0];

    // Class from the major opcode only.
    always_comb begin
        case (opcode)
            fetch_align_pkg::opc_op,
            fetch_align_pkg::opc_op_imm: begin
                cls = fetch_align_pkg::cls_alu;
            end
            fetch_align_pkg::opc_load: begin
                cls = fetch_align_pkg::cls_load;
            end
            fetch_align_pkg::opc_store: begin
                cls = fetch_align_pkg::cls_store;
            end
            fetch_align_pkg::opc_branch: begin
                cls = fetch_align_pkg::cls_branch;
            end
            fetch_align_pkg::opc_jal,
            fetch_align_pkg::opc_jalr: begin
                cls = fetch_align_pkg::cls_jump;
            end
            fetch_align_pkg::opc_lui,
            fetch_align_pkg::opc_auipc: begin
                cls = fetch_align_pkg::cls_lui_auipc;
            end
            fetch_align_pkg::opc_system,
            fetch_align_pkg::opc_misc_mem: begin
                cls = fetch_align_pkg::cls_system;
            end
            default: begin
                cls = fetch_align_pkg::cls_illegal;
            end
        endcase
    end

endmodule

// File: logic/issue_reg.sv
`timescale 1ns/1ps

module issue_reg (
    input  logic                         clk,
    input  logic                         nrst,
    input  fetch_align_pkg::aligned_t    aligned,
    input  logic [31:0]                  expanded,
    input  fetch_align_pkg::inst_class_e rvc_cls,
    input  fetch_align_pkg::inst_class_e word_cls,
    output fetch_align_pkg::issue_t      issue
);

    fetch_align_pkg::issue_t issue_next;

    // Pick the path by instruction length.
    always_comb begin
        issue_next.valid      = aligned.valid;
        issue_next.compressed = aligned.compressed;
        if (aligned.compressed) begin
            issue_next.inst = expanded;
            issue_next.cls  = rvc_cls;
        end else begin
            issue_next.inst = aligned.raw;
            issue_next.cls  = word_cls;
        end
    end

    // Contents follow valid, so an idle cycle leaves valid low.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            issue <= '0;
        end else if (aligned.valid) begin
            issue <= issue_next;
        end else begin
            issue.valid <= 1'b0;
        end
    end

endmodule

// File: logic/fetch_align_top.sv
`timescale 1ns/1ps

module fetch_align_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic [31:0]             fetch_word,
    input  logic                    fetch_valid,
    output logic                    stall,
    output fetch_align_pkg::issue_t issue
);

    fetch_align_pkg::aligned_t    aligned;
    logic [31:0]                  expanded;
    fetch_align_pkg::inst_class_e rvc_cls;
    fetch_align_pkg::inst_class_e word_cls;

    inst_aligner u_aligner (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_word  (fetch_word),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .aligned     (aligned)
    );

    // Both decoders look at every aligned instruction.
    rvc_expand u_expand (
        .aligned  (aligned),
        .expanded (expanded),
        .cls      (rvc_cls)
    );

    inst_predecode u_predecode (
        .aligned (aligned),
        .cls     (word_cls)
    );

    issue_reg u_issue (
        .clk      (clk),
        .nrst     (nrst),
        .aligned  (aligned),
        .expanded (expanded),
        .rvc_cls  (rvc_cls),
        .word_cls (word_cls),
        .issue    (issue)
    );

endmodule

// File: sim/tb_rvc_model.svh
`ifndef TB_RVC_MODEL_SVH
`define TB_RVC_MODEL_SVH

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

// Class of a full 32-bit instruction from its major opcode.
function automatic fetch_align_pkg::inst_class_e opcode_class(input logic [6:0] opc);
    case (opc)
        7'h13, 7'h33: return fetch_align_pkg::cls_alu;
        7'h03: return fetch_align_pkg::cls_load;
        7'h23: return fetch_align_pkg::cls_store;
        7'h63: return fetch_align_pkg::cls_branch;
        7'h67, 7'h6f: return fetch_align_pkg::cls_jump;
        7'h17, 7'h37: return fetch_align_pkg::cls_lui_auipc;
        7'h0f, 7'h73: return fetch_align_pkg::cls_system;
        default: return fetch_align_pkg::cls_illegal;
    endcase
endfunction

// Expected issue entry for one compressed halfword.
function automatic fetch_align_pkg::issue_t expand_rvc(input logic [15:0] h);
    fetch_align_pkg::issue_t r;
    fetch_align_pkg::rvc_u v;
    logic [11:0] imm;
    logic [20:0] joff;
    logic [12:0] boff;
    logic [4:0] rdp;
    logic [4:0] rs1p;
    v = h;
    rdp = {2'b01, h[4:2]};
    rs1p = {2'b01, h[9:7]};
    imm = {{7{h[12]}}, h[6:2]};
    joff = {{10{h[12]}}, h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
    boff = {{5{h[12]}}, h[6:5], h[2], h[11:10], h[4:3], 1'b0};
    r = '{valid: 1'b1, compressed: 1'b1, inst: 32'h0, cls: fetch_align_pkg::cls_illegal};
    case ({v.ci.funct3, v.ci.op})
        5'b000_00: begin
            // Zero-extended nzuimm, zero is reserved.
            imm = {2'b00, h[10:7], h[12:11], h[5], h[6], 2'b00};
            if (imm != 12'd0) begin
                r.inst = {imm, 5'd2, 3'b000, rdp, 7'h13};
                r.cls = fetch_align_pkg::cls_alu;
            end
        end
        5'b010_00, 5'b110_00: begin
            imm = {5'b00000, h[5], h[12:10], h[6], 2'b00};
            if (h[15]) begin
                r.inst = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], 7'h23};
                r.cls = fetch_align_pkg::cls_store;
            end else begin
                r.inst = {imm, rs1p, 3'b010, rdp, 7'h03};
                r.cls = fetch_align_pkg::cls_load;
            end
        end
        5'b000_01, 5'b010_01: begin
            // C.LI reads x0 in place of rd.
            r.inst = {imm, h[14] ? 5'd0 : v.ci.rd, 3'b000, v.ci.rd, 7'h13};
            r.cls = fetch_align_pkg::cls_alu;
        end
        5'b011_01: begin
            if (v.ci.rd != 5'd2 && {h[12], h[6:2]} != 6'd0) begin
                r.inst = {{8{h[12]}}, imm, v.ci.rd, 7'h37};
                r.cls = fetch_align_pkg::cls_lui_auipc;
            end
        end
        5'b101_01: begin
            r.inst = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'h6f};
            r.cls = fetch_align_pkg::cls_jump;
        end
        5'b110_01, 5'b111_01: begin
            r.inst = {boff[12], boff[10:5], 5'd0, rs1p, 2'b00, h[13],
                      boff[4:1], boff[11], 7'h63};
            r.cls = fetch_align_pkg::cls_branch;
        end
        5'b100_10: begin
            // Bit 12 clear is C.MV and set is C.ADD.
            if (v.cr.rs2 != 5'd0) begin
                r.inst = {7'd0, v.cr.rs2, h[12] ? v.cr.rd_rs1 : 5'd0, 3'b000, v.cr.rd_rs1,
                          7'h33};
                r.cls = fetch_align_pkg::cls_alu;
            end
        end
        default: ;
    endcase
    return r;
endfunction

// Random compressed halfword. Selectors 11 to 15 are formats outside the subset.
function automatic logic [15:0] make_rvc(input logic [31:0] rnd);
    logic [79:0] forms;
    logic [4:0] f;
    forms = {5'b010_10, 5'b000_10, 5'b100_01, 5'b100_00, 5'b001_00, 5'b100_10, 5'b100_10,
             5'b111_01, 5'b110_01, 5'b101_01, 5'b011_01, 5'b010_01, 5'b000_01, 5'b110_00,
             5'b010_00, 5'b000_00};
    f = forms[rnd[19:16] * 5 +: 5];
    if (rnd[23:20] == 4'd0) begin
        return 16'h0000;
    end
    return {f[4:2], rnd[10:0], f[1:0]};
endfunction

// Random 32-bit instruction, mostly with a known opcode.
function automatic logic [31:0] make_word32(input logic [31:0] rnd);
    logic [76:0] opcodes;
    opcodes = {7'h73, 7'h6f, 7'h67, 7'h63, 7'h37, 7'h33, 7'h23, 7'h17, 7'h13, 7'h0f, 7'h03};
    if (rnd[3:0] < 4'd11) begin
        return {rnd[31:7], opcodes[rnd[3:0] * 7 +: 7]};
    end
    return {rnd[31:7], rnd[8:4], 2'b11};
endfunction

`endif

// File: sim/tb_fetch_align.sv
`timescale 1ns/1ps

module tb_fetch_align;

    `include "tb_rvc_model.svh"

    logic                    clk;
    logic                    nrst;
    logic [31:0]             fetch_word;
    logic                    fetch_valid;
    logic                    stall;
    fetch_align_pkg::issue_t issue;

    logic [31:0]             seed;
    logic [15:0]             halves[$];
    fetch_align_pkg::issue_t expected[$];
    logic                    word_taken;
    logic                    started;

    fetch_align_top u_dut (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_word  (fetch_word),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .issue       (issue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error: %s is %h, expected %h", name, got, want);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    // A consumed word must issue an instruction one cycle later.
    always @(posedge clk) begin
        word_taken <= nrst && fetch_valid && !stall;
        if (fetch_valid) begin
            started <= 1'b1;
        end
    end

    always @(negedge clk) begin : monitor
        fetch_align_pkg::issue_t want_item;
        if (nrst && !started) begin
            check_value("stall", stall, 1'b0);
            check_value("issue.valid", issue.valid, 1'b0);
        end
        if (word_taken) begin
            check_value("issue.valid", issue.valid, 1'b1);
        end
        if (nrst && issue.valid) begin
            if (expected.size() == 0) begin
                stop_with_failure("An instruction issued when none was expected.");
            end
            want_item = expected.pop_front();
            check_value("issue.compressed", issue.compressed, want_item.compressed);
            check_value("issue.inst", issue.inst, want_item.inst);
            check_value("issue.cls", issue.cls, want_item.cls);
        end
    end

    initial begin
        int          i;
        int          idle;
        int          waited;
        logic [31:0] w;
        logic [15:0] h;
        nrst        = 1'b0;
        fetch_word  = 32'h0;
        fetch_valid = 1'b0;
        word_taken  = 1'b0;
        started     = 1'b0;
        seed        = 32'h9a97dc01;

        // Program stream in halfwords, with the model result per instruction.
        for (i = 0; i < 400; i++) begin
            seed = xorshift(seed);
            w = xorshift(seed);
            if (seed[2:0] < 3'd3) begin
                w = make_word32(w);
                halves.push_back(w[15:0]);
                halves.push_back(w[31:16]);
                expected.push_back('{valid: 1'b1, compressed: 1'b0, inst: w,
                                     cls: opcode_class(w[6:0])});
            end else begin
                h = make_rvc(w);
                halves.push_back(h);
                expected.push_back(expand_rvc(h));
            end
            seed = w;
        end
        if (halves.size() % 2 != 0) begin
            halves.push_back(16'h0001);
            expected.push_back(expand_rvc(16'h0001));
        end

        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        repeat (3) @(posedge clk);

        for (i = 0; i < halves.size(); i += 2) begin
            seed = xorshift(seed);
            idle = (seed[1:0] == 2'b00) ? seed[3:2] : 0;
            repeat (idle) begin
                fetch_valid <= 1'b0;
                @(posedge clk);
            end
            fetch_word  <= {halves[i + 1], halves[i]};
            fetch_valid <= 1'b1;
            @(posedge clk);
            waited = 0;
            // Word stays on the bus until a cycle without stall.
            while (stall) begin
                waited++;
                if (waited > 4) begin
                    stop_with_failure("Stall stayed high and the fetch word was never taken.");
                end
                @(posedge clk);
            end
        end
        fetch_valid <= 1'b0;

        waited = 0;
        while (expected.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);
        if (expected.size() != 0) begin
            stop_with_failure("Some instructions were never issued.");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+sim
logic/fetch_align_pkg.sv
logic/inst_aligner.sv
logic/rvc_expand.sv
logic/inst_predecode.sv
logic/issue_reg.sv
logic/fetch_align_top.sv
sim/tb_fetch_align.sv
